// File: rtl/ffu_config.svh
// ffu datapath configuration
`ifndef FFU_CONFIG_SVH
`define FFU_CONFIG_SVH

// frf word and ecc
`define FFU_DATA_W  64
`define FFU_HALF_W  32
`define FFU_CHK_W   7    // 6 hamming bits + overall parity
`define FFU_SYND_W  6

// threads
`define FFU_NUM_THR 4
`define FFU_THR_W   2

// stored architectural state
`define FFU_FSR_W   28   // live fsr bits only
`define FFU_GSR_W   37   // mask + scale

`endif

// File: rtl/ffu_pkg.sv
// ffu shared types
`include "ffu_config.svh"

package ffu_pkg;

   typedef logic [`FFU_THR_W-1:0] thr_id_t;

   // stored fsr, reserved and constant bits dropped
   typedef struct packed {
      logic [5:0] fcc321;
      logic [1:0] rnd;
      logic [4:0] tem;
      logic [2:0] ftt;
      logic [1:0] fcc0;
      logic [4:0] aexc;
      logic [4:0] cexc;
   } fsr_t;

   typedef struct packed {
      logic [`FFU_HALF_W-1:0]            mask;
      logic [`FFU_GSR_W-`FFU_HALF_W-1:0] scale;
   } gsr_t;

   typedef struct packed {
      logic                   pflag;   // overall parity mismatch
      logic [`FFU_SYND_W-1:0] cflag;   // hamming syndrome
   } ecc_synd_t;

   // architectural fsr as seen by ldxfsr / stxfsr
   typedef struct packed {
      logic [25:0] rsvd_hi;
      logic [5:0]  fcc321;     // 37:32
      logic [1:0]  rnd;        // 31:30
      logic [1:0]  rsvd_rnd;
      logic [4:0]  tem;        // 27:23
      logic [5:0]  rsvd_ver;   // ns, rsvd, ver
      logic [2:0]  ftt;        // 16:14
      logic [1:0]  rsvd_qne;   // qne, rsvd
      logic [1:0]  fcc0;
      logic [4:0]  aexc;
      logic [4:0]  cexc;
   } fsr_image_t;

   typedef union packed {
      logic [`FFU_DATA_W-1:0] raw;
      fsr_image_t             fsr;
   } lsu_word_u;

   typedef enum logic {
      ST_FRF = 1'b0,
      ST_FSR = 1'b1
   } st_src_e;

endpackage

// File: rtl/ecc39_correct.sv
// secded check for one frf half
`include "ffu_config.svh"

module ecc39_correct (
   input  logic [`FFU_HALF_W-1:0] data,
   input  logic [`FFU_CHK_W-1:0]  chk,
   output logic [`FFU_HALF_W-1:0] data_fix,
   output ffu_pkg::ecc_synd_t     synd
);

   localparam int SW   = `FFU_SYND_W;
   localparam int CW_W = `FFU_HALF_W + `FFU_SYND_W;   // positions 1..38

   logic [CW_W:1] cw;       // received codeword
   logic [CW_W:1] cw_fix;
   logic [SW-1:0] cflag;
   logic          pflag;

   // check bits at powers of two, data fills the gaps
   always_comb begin : build_cw
      int d_idx;
      int c_idx;
      d_idx = 0;
      c_idx = 0;
      for (int p = 1; p <= CW_W; p++) begin
         if ((p & (p - 1)) == 0) begin
            cw[p] = chk[c_idx];
            c_idx++;
         end else begin
            cw[p] = data[d_idx];
            d_idx++;
         end
      end
   end

   // xor of the positions of all set bits
   always_comb begin : calc_synd
      cflag = '0;
      for (int p = 1; p <= CW_W; p++) begin
         if (cw[p]) cflag = cflag ^ SW'(p);
      end
   end

   assign pflag = ^{chk[`FFU_CHK_W-1], cw};

   // single error only; parity bit or double error leaves cw alone
   always_comb begin : fix_cw
      cw_fix = cw;
      if (pflag && (cflag != '0) && (int'(cflag) <= CW_W)) begin
         cw_fix[cflag] = ~cw[cflag];
      end
   end

   always_comb begin : gather_data
      int d_idx;
      d_idx = 0;
      data_fix = '0;
      for (int p = 1; p <= CW_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            data_fix[d_idx] = cw_fix[p];
            d_idx++;
         end
      end
   end

   assign synd = '{pflag: pflag, cflag: cflag};

endmodule

// File: rtl/frf_ecc_check.sv
// frf read check and correct
`include "ffu_config.svh"

module frf_ecc_check (
   input  logic                                      rclk,
   input  logic                                      rst_n,
   input  logic                                      frf_rd,
   input  logic [2*(`FFU_HALF_W+`FFU_CHK_W)-1:0]     frf_data,
   output logic [`FFU_DATA_W-1:0]                    corr_data,
   output ffu_pkg::ecc_synd_t                        synd_low,
   output ffu_pkg::ecc_synd_t                        synd_high
);
   import ffu_pkg::*;

   localparam int H = `FFU_HALF_W;
   localparam int C = `FFU_CHK_W;

   logic [H-1:0] data_low;
   logic [H-1:0] data_high;
   logic [C-1:0] chk_low;
   logic [C-1:0] chk_high;
   logic [H-1:0] fix_low;
   logic [H-1:0] fix_high;
   ecc_synd_t    synd_low_nxt;
   ecc_synd_t    synd_high_nxt;

   // frf layout {chk_hi, data_hi, chk_lo, data_lo}
   assign data_low  = frf_data[H-1:0];
   assign chk_low   = frf_data[H+C-1:H];
   assign data_high = frf_data[2*H+C-1:H+C];
   assign chk_high  = frf_data[2*(H+C)-1:2*H+C];

   ecc39_correct u_ecc_low  (.data(data_low),  .chk(chk_low),
                             .data_fix(fix_low),  .synd(synd_low_nxt));
   ecc39_correct u_ecc_high (.data(data_high), .chk(chk_high),
                             .data_fix(fix_high), .synd(synd_high_nxt));

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         corr_data <= '0;
         synd_low  <= '0;
         synd_high <= '0;
      end else if (frf_rd) begin   // hold until next read
         corr_data <= {fix_high, fix_low};
         synd_low  <= synd_low_nxt;
         synd_high <= synd_high_nxt;
      end
   end

   a_frf_rd_known: assert property (@(posedge rclk) disable iff (!rst_n) !$isunknown(frf_rd));

endmodule

// File: rtl/fp_state_regs.sv
// per-thread fsr and gsr storage
`include "ffu_config.svh"

module fp_state_regs (
   input  logic               rclk,
   input  logic               rst_n,
   input  logic               fsr_ld,
   input  ffu_pkg::thr_id_t   fsr_ld_thr,
   input  ffu_pkg::lsu_word_u ld_data,
   input  logic               fpu_wr,
   input  ffu_pkg::thr_id_t   fpu_thr,
   input  logic [7:0]         fpu_fcc,
   input  logic [2:0]         fpu_ftt,
   input  logic [9:0]         fpu_exc,
   input  logic               gsr_wr,
   input  ffu_pkg::thr_id_t   gsr_wr_thr,
   input  ffu_pkg::gsr_t      wsr_data,
   input  ffu_pkg::thr_id_t   fp_thr,
   input  ffu_pkg::thr_id_t   thr_e,
   output ffu_pkg::fsr_t      cur_fsr,
   output ffu_pkg::gsr_t      cur_gsr
);
   import ffu_pkg::*;

   localparam int NT = `FFU_NUM_THR;

   logic [`FFU_FSR_W-1:0] fsr_q [NT];     // only the live fsr bits
   logic [`FFU_GSR_W-1:0] gsr_q [NT];
   fsr_t                  fsr_nxt [NT];
   fsr_image_t            ld_img;

   assign ld_img = ld_data.fsr;   // load word viewed as fsr image

   ////////////////////////////////////////
   // fsr update
   ////////////////////////////////////////
   always_comb begin
      for (int t = 0; t < NT; t++) begin
         fsr_nxt[t] = fsr_t'(fsr_q[t]);
         if (fsr_ld && (fsr_ld_thr == thr_id_t'(t))) begin
            // ftt is not loadable
            fsr_nxt[t].fcc321 = ld_img.fcc321;
            fsr_nxt[t].rnd    = ld_img.rnd;
            fsr_nxt[t].tem    = ld_img.tem;
            fsr_nxt[t].fcc0   = ld_img.fcc0;
            fsr_nxt[t].aexc   = ld_img.aexc;
            fsr_nxt[t].cexc   = ld_img.cexc;
         end else if (fpu_wr && (fpu_thr == thr_id_t'(t))) begin
            fsr_nxt[t].fcc321 = fpu_fcc[7:2];   // fcc3,2,1
            fsr_nxt[t].fcc0   = fpu_fcc[1:0];
            fsr_nxt[t].ftt    = fpu_ftt;
            fsr_nxt[t].aexc   = fpu_exc[9:5];
            fsr_nxt[t].cexc   = fpu_exc[4:0];
         end
      end
   end

   ////////////////////////////////////////
   // state registers
   ////////////////////////////////////////
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         for (int t = 0; t < NT; t++) begin
            fsr_q[t] <= '0;
            gsr_q[t] <= '0;
         end
      end else begin
         for (int t = 0; t < NT; t++) begin
            fsr_q[t] <= fsr_nxt[t];
            if (gsr_wr && (gsr_wr_thr == thr_id_t'(t))) begin
               gsr_q[t] <= wsr_data;   // full gsr from wsr
            end
         end
      end
   end

   // current thread views
   assign cur_fsr = fsr_t'(fsr_q[fp_thr]);
   assign cur_gsr = gsr_t'(gsr_q[thr_e]);

   // controller never aims a load and an fpu result at one thread
   a_no_fsr_clash: assert property (
      @(posedge rclk) disable iff (!rst_n)
      !(fsr_ld && fpu_wr && (fsr_ld_thr == fpu_thr))
   );

endmodule

// File: rtl/lsu_store_mux.sv
// store data to the load/store unit
`include "ffu_config.svh"

module lsu_store_mux (
   input  logic                   rclk,
   input  logic                   rst_n,
   input  logic                   st_req,
   input  ffu_pkg::st_src_e       st_src,
   input  logic [`FFU_DATA_W-1:0] corr_data,
   input  ffu_pkg::fsr_t          cur_fsr,
   output logic [`FFU_DATA_W-1:0] st_data,
   output logic                   st_vld
);
   import ffu_pkg::*;

   lsu_word_u fsr_word;

   // expand stored fsr with reserved fields at zero
   always_comb begin
      fsr_word.raw        = '0;
      fsr_word.fsr.fcc321 = cur_fsr.fcc321;
      fsr_word.fsr.rnd    = cur_fsr.rnd;
      fsr_word.fsr.tem    = cur_fsr.tem;
      fsr_word.fsr.ftt    = cur_fsr.ftt;
      fsr_word.fsr.fcc0   = cur_fsr.fcc0;
      fsr_word.fsr.aexc   = cur_fsr.aexc;
      fsr_word.fsr.cexc   = cur_fsr.cexc;
   end

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         st_vld <= 1'b0;
      end else begin
         st_vld <= st_req;   // one-cycle pulse per request
      end
   end

   always_ff @(posedge rclk) begin
      if (st_req) begin
         st_data <= (st_src == ST_FSR) ? fsr_word.raw : corr_data;
      end
   end

   // a request needs a known source
   a_st_req_known: assert property (
      @(posedge rclk) disable iff (!rst_n)
      !$isunknown(st_req) && (!st_req || !$isunknown(st_src))
   );

endmodule

// File: rtl/ffu_top.sv
// ffu storage and check datapath
`include "ffu_config.svh"

module ffu_top (
   input  logic                                  rclk,
   input  logic                                  rst_n,
   // frf read
   input  logic                                  frf_rd,
   input  logic [2*(`FFU_HALF_W+`FFU_CHK_W)-1:0] frf_data,
   output logic [`FFU_DATA_W-1:0]                corr_data,
   output ffu_pkg::ecc_synd_t                    synd_low,
   output ffu_pkg::ecc_synd_t                    synd_high,
   // fsr / gsr updates
   input  logic                                  fsr_ld,
   input  ffu_pkg::thr_id_t                      fsr_ld_thr,
   input  ffu_pkg::lsu_word_u                    ld_data,
   input  logic                                  fpu_wr,
   input  ffu_pkg::thr_id_t                      fpu_thr,
   input  logic [7:0]                            fpu_fcc,
   input  logic [2:0]                            fpu_ftt,
   input  logic [9:0]                            fpu_exc,
   input  logic                                  gsr_wr,
   input  ffu_pkg::thr_id_t                      gsr_wr_thr,
   input  ffu_pkg::gsr_t                         wsr_data,
   input  ffu_pkg::thr_id_t                      fp_thr,
   input  ffu_pkg::thr_id_t                      thr_e,
   output ffu_pkg::fsr_t                         cur_fsr,
   output ffu_pkg::gsr_t                         cur_gsr,
   // store to lsu
   input  logic                                  st_req,
   input  ffu_pkg::st_src_e                      st_src,
   output logic [`FFU_DATA_W-1:0]                st_data,
   output logic                                  st_vld
);

   frf_ecc_check u_ecc (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .frf_rd    (frf_rd),
      .frf_data  (frf_data),
      .corr_data (corr_data),
      .synd_low  (synd_low),
      .synd_high (synd_high)
   );

   fp_state_regs u_state (
      .rclk       (rclk),
      .rst_n      (rst_n),
      .fsr_ld     (fsr_ld),
      .fsr_ld_thr (fsr_ld_thr),
      .ld_data    (ld_data),
      .fpu_wr     (fpu_wr),
      .fpu_thr    (fpu_thr),
      .fpu_fcc    (fpu_fcc),
      .fpu_ftt    (fpu_ftt),
      .fpu_exc    (fpu_exc),
      .gsr_wr     (gsr_wr),
      .gsr_wr_thr (gsr_wr_thr),
      .wsr_data   (wsr_data),
      .fp_thr     (fp_thr),
      .thr_e      (thr_e),
      .cur_fsr    (cur_fsr),
      .cur_gsr    (cur_gsr)
   );

   // frf word or fsr image, one cycle after st_req
   lsu_store_mux u_store (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .st_req    (st_req),
      .st_src    (st_src),
      .corr_data (corr_data),
      .cur_fsr   (cur_fsr),
      .st_data   (st_data),
      .st_vld    (st_vld)
   );

endmodule

// File: dv/ffu_tb.sv
// ffu datapath testbench
`include "ffu_config.svh"

module ffu_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import ffu_pkg::*;

   localparam int CLK_NS   = 4;
   localparam int NUM_ROWS = 20;

   typedef enum logic [2:0] {OP_FRF, OP_LD, OP_FPU, OP_GSR, OP_ST} op_e;

   // flip counts per half in err with low in [1:0] and high in [3:2]
   typedef struct packed {
      op_e         op;
      thr_id_t     thr;
      logic [31:0] seed;
      logic [3:0]  err;
   } row_t;

   logic rclk, rst_n, frf_rd, fsr_ld, fpu_wr, gsr_wr, st_req, st_vld;
   logic [77:0] frf_data;
   logic [63:0] corr_data, st_data;
   logic [7:0] fpu_fcc;
   logic [2:0] fpu_ftt;
   logic [9:0] fpu_exc;
   ecc_synd_t synd_low, synd_high;
   thr_id_t fsr_ld_thr, fpu_thr, gsr_wr_thr, fp_thr, thr_e;
   lsu_word_u ld_data;
   gsr_t wsr_data, cur_gsr;
   fsr_t cur_fsr;
   st_src_e st_src;

   row_t rows [NUM_ROWS];
   fsr_t ref_fsr [`FFU_NUM_THR];   // reference state
   gsr_t ref_gsr [`FFU_NUM_THR];
   logic [31:0] rng;
   int err_val;
   int err_miss;

   ffu_top i_dut (.*);

   initial begin
      rclk = 1'b0;
      forever #(CLK_NS / 2) rclk = ~rclk;
   end

   // watchdog sized from the row count
   initial begin
      #((NUM_ROWS * 10 + 8 + 8) * CLK_NS);
      $display("Watchdog timeout: the test did not finish in time");
      $display("Result: FAILED");
      $finish;
   end

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   // bit p-1 holds position p and bit 38 the overall parity
   function automatic logic [38:0] ecc_encode(input logic [31:0] d);
      logic [38:0] cw;
      logic [5:0]  s;
      int          di;
      cw = '0;
      s  = '0;
      di = 0;
      for (int p = 1; p <= 38; p++) begin
         if ((p & (p - 1)) != 0) begin
            cw[p-1] = d[di];
            if (d[di]) s = s ^ 6'(p);
            di++;
         end
      end
      for (int k = 0; k < 6; k++) cw[(1 << k) - 1] = s[k];   // cancels the syndrome
      cw[38] = ^cw[37:0];
      return cw;
   endfunction

   // codeword back to the frf half layout {chk, data}
   function automatic logic [38:0] cw_to_half(input logic [38:0] cw);
      logic [31:0] d;
      logic [6:0]  c;
      int          di;
      int          ci;
      di = 0;
      ci = 0;
      for (int p = 1; p <= 38; p++) begin
         if ((p & (p - 1)) == 0) begin
            c[ci] = cw[p-1];
            ci++;
         end else begin
            d[di] = cw[p-1];
            di++;
         end
      end
      c[6] = cw[38];
      return {c, d};
   endfunction

   function automatic logic [63:0] fsr_image(input fsr_t f);
      return {26'b0, f.fcc321, f.rnd, 2'b0, f.tem, 6'b0, f.ftt, 2'b0, f.fcc0, f.aexc, f.cexc};
   endfunction

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////
   task automatic check_data(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
         err_val++;
      end
   endtask

   task automatic check_synd(input string what, input ecc_synd_t got, input ecc_synd_t exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
         err_val++;
      end
   endtask

   task automatic check_fsr(input string what, input fsr_t got, input fsr_t exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
         err_val++;
      end
   endtask

   task automatic check_gsr(input string what, input gsr_t got, input gsr_t exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
         err_val++;
      end
   endtask

   ////////////////////////////////////////
   // operations entered and left on a falling edge
   ////////////////////////////////////////
   task automatic issue_store(input st_src_e src, output logic [63:0] data, output bit seen);
      int n;
      st_req = 1'b1;
      st_src = src;
      @(negedge rclk);
      st_req = 1'b0;
      n = 0;
      while (!st_vld && n < 4) begin
         @(negedge rclk);
         n++;
      end
      seen = st_vld;
      data = st_data;
      if (!seen) begin
         $display("Store request at %0t ns never produced st_vld", $time);
         err_miss++;
      end else begin
         @(negedge rclk);
         if (st_vld !== 1'b0) begin
            $display("Fail at %0t ns: st_vld held for more than one cycle", $time);
            err_val++;
         end
      end
   endtask

   task automatic read_frf(input row_t r);
      logic [31:0] d;
      logic [38:0] bad;
      logic [38:0] half [2];
      logic [31:0] exp_d [2];
      ecc_synd_t   exp_s [2];
      logic [63:0] got;
      bit          seen;
      int          nflip;
      int          p1;
      int          p2;
      for (int h = 0; h < 2; h++) begin
         d     = next_rand();
         bad   = ecc_encode(d);
         nflip = (h == 0) ? r.err[1:0] : r.err[3:2];
         p1    = next_rand() % 38 + 1;
         p2    = (p1 + next_rand() % 37) % 38 + 1;   // never equal to p1
         exp_s[h] = '0;
         if (nflip >= 1) begin
            bad[p1-1] = ~bad[p1-1];
            exp_s[h].pflag = ~exp_s[h].pflag;
            exp_s[h].cflag = exp_s[h].cflag ^ 6'(p1);
         end
         if (nflip >= 2) begin
            bad[p2-1] = ~bad[p2-1];
            exp_s[h].pflag = ~exp_s[h].pflag;
            exp_s[h].cflag = exp_s[h].cflag ^ 6'(p2);
         end
         half[h]  = cw_to_half(bad);
         exp_d[h] = (nflip >= 2) ? half[h][31:0] : d;   // double error passes through
      end
      frf_data = {half[1], half[0]};
      frf_rd   = 1'b1;
      @(negedge rclk);
      frf_rd = 1'b0;
      issue_store(ST_FRF, got, seen);
      if (seen) check_data("st_data from frf", got, {exp_d[1], exp_d[0]});
      check_data("corr_data", corr_data, {exp_d[1], exp_d[0]});
      check_synd("synd_low", synd_low, exp_s[0]);
      check_synd("synd_high", synd_high, exp_s[1]);
   endtask

   task automatic store_fsr(input thr_id_t t);
      logic [63:0] got;
      bit          seen;
      fp_thr = t;
      issue_store(ST_FSR, got, seen);
      if (seen) check_data("st_data fsr image", got, fsr_image(ref_fsr[t]));
      check_fsr("cur_fsr", cur_fsr, ref_fsr[t]);
   endtask

   task automatic check_threads();
      for (int t = 0; t < `FFU_NUM_THR; t++) begin
         fp_thr = thr_id_t'(t);
         thr_e  = thr_id_t'(t);
         @(negedge rclk);
         check_fsr($sformatf("cur_fsr thread %0d", t), cur_fsr, ref_fsr[t]);
         check_gsr($sformatf("cur_gsr thread %0d", t), cur_gsr, ref_gsr[t]);
      end
   endtask

   task automatic apply_row(input row_t r);
      logic [63:0] w;
      rng = xorshift(rng ^ r.seed);
      if (rng == 0) rng = 32'hdeeef9f5;
      w = {next_rand(), next_rand()};
      case (r.op)
         OP_FRF: read_frf(r);
         OP_LD: begin
            ld_data.raw = w;
            fsr_ld      = 1'b1;
            fsr_ld_thr  = r.thr;
            @(negedge rclk);
            fsr_ld = 1'b0;
            ref_fsr[r.thr].fcc321 = w[37:32];   // ftt stays
            ref_fsr[r.thr].rnd    = w[31:30];
            ref_fsr[r.thr].tem    = w[27:23];
            ref_fsr[r.thr].fcc0   = w[11:10];
            ref_fsr[r.thr].aexc   = w[9:5];
            ref_fsr[r.thr].cexc   = w[4:0];
            store_fsr(r.thr);
         end
         OP_FPU: begin
            fpu_wr  = 1'b1;
            fpu_thr = r.thr;
            fpu_fcc = w[7:0];
            fpu_ftt = w[10:8];
            fpu_exc = w[20:11];
            @(negedge rclk);
            fpu_wr = 1'b0;
            ref_fsr[r.thr].fcc321 = w[7:2];   // rnd, tem kept
            ref_fsr[r.thr].fcc0   = w[1:0];
            ref_fsr[r.thr].ftt    = w[10:8];
            ref_fsr[r.thr].aexc   = w[20:16];
            ref_fsr[r.thr].cexc   = w[15:11];
            check_threads();
         end
         OP_GSR: begin
            gsr_wr     = 1'b1;
            gsr_wr_thr = r.thr;
            wsr_data   = w[36:0];
            @(negedge rclk);
            gsr_wr = 1'b0;
            ref_gsr[r.thr] = w[36:0];
            check_threads();
         end
         default: store_fsr(r.thr);
      endcase
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin
      rst_n = 1'b0;
      frf_rd = 1'b0;
      frf_data = '0;
      fsr_ld = 1'b0;
      fsr_ld_thr = '0;
      ld_data = '0;
      fpu_wr = 1'b0;
      fpu_thr = '0;
      fpu_fcc = '0;
      fpu_ftt = '0;
      fpu_exc = '0;
      gsr_wr = 1'b0;
      gsr_wr_thr = '0;
      wsr_data = '0;
      fp_thr = '0;
      thr_e = '0;
      st_req = 1'b0;
      st_src = ST_FRF;
      rng = 32'hdeeef9f5;
      err_val = 0;
      err_miss = 0;
      for (int t = 0; t < `FFU_NUM_THR; t++) begin
         ref_fsr[t] = '0;
         ref_gsr[t] = '0;
      end
      rows = '{
         '{OP_FRF, 2'd0, 32'h0000_0000, 4'h0}, '{OP_FRF, 2'd0, 32'h1234_5678, 4'h1},
         '{OP_FRF, 2'd0, 32'h0bad_cafe, 4'h4}, '{OP_FRF, 2'd0, 32'h5a5a_0f0f, 4'h2},
         '{OP_FRF, 2'd0, 32'h0f0f_5a5a, 4'h8}, '{OP_FRF, 2'd0, 32'h3c3c_c3c3, 4'h5},
         '{OP_FRF, 2'd0, 32'h7e57_0001, 4'h9}, '{OP_LD,  2'd0, 32'h1111_2222, 4'h0},
         '{OP_LD,  2'd2, 32'h3333_4444, 4'h0}, '{OP_FPU, 2'd0, 32'h5555_6666, 4'h0},
         '{OP_FPU, 2'd1, 32'h7777_8888, 4'h0}, '{OP_FPU, 2'd2, 32'h9999_aaaa, 4'h0},
         '{OP_FPU, 2'd3, 32'hbbbb_cccc, 4'h0}, '{OP_GSR, 2'd1, 32'hdddd_eeee, 4'h0},
         '{OP_GSR, 2'd3, 32'h0f1e_2d3c, 4'h0}, '{OP_ST,  2'd1, 32'h4b5a_6978, 4'h0},
         '{OP_LD,  2'd3, 32'h8796_a5b4, 4'h0}, '{OP_FPU, 2'd3, 32'hc3d2_e1f0, 4'h0},
         '{OP_ST,  2'd3, 32'h1357_9bdf, 4'h0}, '{OP_FRF, 2'd0, 32'h2468_ace0, 4'h0}
      };
      repeat (8) @(negedge rclk);
      rst_n = 1'b1;
      @(negedge rclk);
      // everything reads zero out of reset
      check_data("corr_data after reset", corr_data, '0);
      check_synd("synd_low after reset", synd_low, '0);
      check_synd("synd_high after reset", synd_high, '0);
      if (st_vld !== 1'b0) begin
         $display("Fail at %0t ns: st_vld high after reset", $time);
         err_val++;
      end
      check_threads();
      for (int i = 0; i < NUM_ROWS; i++) apply_row(rows[i]);
      $display("Checks done: %0d wrong values, %0d missing st_vld", err_val, err_miss);
      if (err_val == 0 && err_miss == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: build.f
+incdir+rtl
rtl/ffu_pkg.sv
rtl/ecc39_correct.sv
rtl/frf_ecc_check.sv
rtl/fp_state_regs.sv
rtl/lsu_store_mux.sv
rtl/ffu_top.sv
dv/ffu_tb.sv

// File: Makefile
OBJ = obj_dir
LOG = sim.log

all: run

run:
	verilator --binary --assert --timing -j 0 -f build.f --top-module ffu_tb -Mdir $(OBJ) -o ffu_tb
	./$(OBJ)/ffu_tb | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module ffu_tb

clean:
	rm -rf $(OBJ) $(LOG)

.PHONY: all run lint clean
